//--- include/icache_macros.svh
/* Cache geometry. Ways, sets and words per line must be powers of two.
   The LFSR seed must be non-zero. */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

`define ICACHE_WAYS       4
`define ICACHE_SETS       16
`define ICACHE_WORDS      4
`define ICACHE_ADDR_W     32
`define ICACHE_LFSR_SEED  7'h5b

// Derived field widths and positions
`define ICACHE_WAY_W      $clog2(`ICACHE_WAYS)
`define ICACHE_INDEX_W    $clog2(`ICACHE_SETS)
`define ICACHE_OFFSET_W   $clog2(`ICACHE_WORDS)
`define ICACHE_INDEX_LSB  (2 + `ICACHE_OFFSET_W)
`define ICACHE_TAG_LSB    (`ICACHE_INDEX_LSB + `ICACHE_INDEX_W)
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_TAG_LSB)

`endif

//--- hw/icache_pkg.sv
/* Shared cache types. Byte address splits into
   tag | index | word offset | 2 byte bits. */
`include "icache_macros.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0]   paddr_t;
  typedef logic [31:0]                 word_t;
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
  typedef logic [`ICACHE_WAY_W-1:0]    way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]     way_mask_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    refill,
    respond,
    fence
  } ctrl_state_t;

endpackage

//--- hw/icache_way_ram.sv
/* One cache way. All reads are synchronous and return old data on a
   same-cycle write. Tag and data arrays power up undefined. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_way_ram (
  input  logic               clk,
  input  logic               rst,
  input  icache_pkg::index_t  index,
  input  icache_pkg::offset_t offset,
  input  logic               tag_we,
  input  logic               valid_in,
  input  icache_pkg::tag_t    tag_in,
  input  logic               word_we,
  input  icache_pkg::word_t   word_in,
  output logic               valid_out,
  output icache_pkg::tag_t    tag_out,
  output icache_pkg::word_t   word_out
);
  import icache_pkg::*;

  // Valid bits live in flops so a fence can clear a set per cycle
  logic [`ICACHE_SETS-1:0] valid_q;
  tag_t                    tag_mem  [`ICACHE_SETS];
  word_t                   data_mem [`ICACHE_SETS*`ICACHE_WORDS];

  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[index] <= tag_in;
      valid_q[index] <= valid_in;
    end
    if (word_we) begin
      data_mem[{index, offset}] <= word_in;
    end
    tag_out  <= tag_mem[index];
    word_out <= data_mem[{index, offset}];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_q[index];
    end
  end

endmodule

//--- hw/icache_victim_select.sv
/* Replacement choice. Lowest invalid way wins, else the LFSR low bits.
   The LFSR only moves on step, once per miss. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_victim_select (
  input  logic                 clk,
  input  logic                 rst,
  input  icache_pkg::way_mask_t valid_mask,
  input  logic                 step,
  output icache_pkg::way_idx_t  victim
);
  import icache_pkg::*;

  logic [6:0] lfsr_q;
  logic       lfsr_fb;

  // Taps 6 and 5 give a maximal length sequence
  assign lfsr_fb = lfsr_q[6] ^ lfsr_q[5];

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= `ICACHE_LFSR_SEED;
    end else if (step) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_fb};
    end
  end

  // Scan from the top so the lowest invalid way is the last to land
  always_comb begin
    victim = lfsr_q[`ICACHE_WAY_W-1:0];
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (!valid_mask[i]) begin
        victim = way_idx_t'(i);
      end
    end
  end

endmodule

//--- hw/icache_refill.sv
/* Line refill over Wishbone classic, one read cycle per word.
   cyc/stb drop for one cycle between words. line_addr must hold
   steady until done. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_refill (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  icache_pkg::paddr_t   line_addr,
  input  icache_pkg::word_t    wb_dat_i,
  input  logic                wb_ack,
  output logic                wb_cyc,
  output logic                wb_stb,
  output icache_pkg::paddr_t   wb_adr,
  output logic                word_we,
  output icache_pkg::offset_t  word_offset,
  output icache_pkg::word_t    word_data,
  output logic                done
);
  import icache_pkg::*;

  logic    busy_q;
  logic    req_q;
  logic    done_q;
  offset_t cnt_q;
  logic    last;

  assign last = (cnt_q == offset_t'(`ICACHE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
        cnt_q  <= '0;
      end else if (req_q && wb_ack) begin
        req_q <= 1'b0;
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (busy_q && !req_q) begin
        // Next word after the idle gap
        req_q <= 1'b1;
      end
    end
  end

  assign wb_cyc      = req_q;
  assign wb_stb      = req_q;
  assign wb_adr      = {line_addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB], cnt_q, 2'b00};
  assign word_we     = req_q & wb_ack;
  assign word_offset = cnt_q;
  assign word_data   = wb_dat_i;
  assign done        = done_q;

endmodule

//--- hw/icache_ctrl.sv
/* Blocking cache control, one fetch in flight. A hit answers two cycles
   after acceptance. After reset the valid bits are walked clear before
   the first fetch is taken. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    fetch_valid,
  input  icache_pkg::paddr_t                       fetch_addr,
  input  logic                                    fence_valid,
  input  icache_pkg::way_mask_t                    way_valid,
  input  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]      way_tag,
  input  icache_pkg::word_t [`ICACHE_WAYS-1:0]      way_word,
  input  icache_pkg::way_idx_t                     victim,
  input  logic                                    refill_word_we,
  input  icache_pkg::offset_t                      refill_offset,
  input  icache_pkg::word_t                        refill_data,
  input  logic                                    refill_done,
  output logic                                    fetch_ready,
  output logic                                    fence_ready,
  output logic                                    fence_done,
  output logic                                    resp_valid,
  output icache_pkg::word_t                        resp_data,
  output logic                                    resp_hit,
  output icache_pkg::index_t                       ram_index,
  output icache_pkg::offset_t                      ram_offset,
  output icache_pkg::way_mask_t                    tag_we,
  output icache_pkg::way_mask_t                    word_we,
  output logic                                    valid_in,
  output icache_pkg::tag_t                         tag_in,
  output logic                                    refill_start,
  output icache_pkg::paddr_t                       refill_line_addr,
  output logic                                    victim_step
);
  import icache_pkg::*;

  ctrl_state_t state_q;
  paddr_t      req_addr_q;
  logic        rd_q;
  index_t      fence_idx_q;
  logic        init_q;
  logic        fence_done_q;
  way_idx_t    victim_q;
  word_t       resp_word_q;

  tag_t        req_tag;
  index_t      req_index;
  offset_t     req_offset;
  way_mask_t   hit_mask;
  word_t       hit_word;
  logic        lookup_hit;
  logic        lookup_miss;

  assign req_tag    = req_addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
  assign req_index  = req_addr_q[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
  assign req_offset = req_addr_q[2 +: `ICACHE_OFFSET_W];

  // ====================
  // Tag compare
  always_comb begin
    hit_word = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      hit_mask[i] = way_valid[i] && (way_tag[i] == req_tag);
      if (hit_mask[i]) begin
        hit_word = hit_word | way_word[i];
      end
    end
  end

  // RAM outputs are valid on the second lookup cycle
  assign lookup_hit  = (state_q == lookup) && rd_q && (|hit_mask);
  assign lookup_miss = (state_q == lookup) && rd_q && !(|hit_mask);

  // ====================
  // State machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= fence;
      rd_q         <= 1'b0;
      fence_idx_q  <= '0;
      init_q       <= 1'b1;
      fence_done_q <= 1'b0;
      victim_q     <= '0;
    end else begin
      fence_done_q <= 1'b0;
      case (state_q)
        idle: begin
          if (fence_valid) begin
            state_q     <= fence;
            fence_idx_q <= '0;
          end else if (fetch_valid) begin
            state_q <= lookup;
            rd_q    <= 1'b0;
          end
        end
        lookup: begin
          if (!rd_q) begin
            rd_q <= 1'b1;
          end else if (|hit_mask) begin
            state_q <= idle;
          end else begin
            state_q  <= refill;
            victim_q <= victim;
          end
        end
        refill: begin
          if (refill_done) begin
            state_q <= respond;
          end
        end
        respond: state_q <= idle;
        fence: begin
          fence_idx_q <= fence_idx_q + 1'b1;
          if (fence_idx_q == index_t'(`ICACHE_SETS - 1)) begin
            state_q      <= idle;
            // Only a requested fence reports back
            fence_done_q <= !init_q;
            init_q       <= 1'b0;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ready && fetch_valid) begin
      req_addr_q <= fetch_addr;
    end
    if (state_q == refill && refill_word_we && refill_offset == req_offset) begin
      resp_word_q <= refill_data;
    end
  end

  // ====================
  // Outputs and RAM control
  assign fence_ready = (state_q == idle);
  assign fetch_ready = (state_q == idle) && !fence_valid;
  assign fence_done  = fence_done_q;

  assign resp_valid = lookup_hit || (state_q == respond);
  assign resp_hit   = lookup_hit;
  assign resp_data  = (state_q == respond) ? resp_word_q : hit_word;

  assign refill_start     = lookup_miss;
  assign victim_step      = lookup_miss;
  assign refill_line_addr = {req_addr_q[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB],
                             {`ICACHE_INDEX_LSB{1'b0}}};

  assign ram_index  = (state_q == fence) ? fence_idx_q : req_index;
  assign ram_offset = (state_q == refill) ? refill_offset : req_offset;
  assign valid_in   = (state_q != fence);
  assign tag_in     = req_tag;

  always_comb begin
    tag_we  = '0;
    word_we = '0;
    if (state_q == fence) begin
      tag_we = '1;
    end else if (state_q == refill) begin
      if (refill_done) begin
        tag_we = way_mask_t'(1) << victim_q;
      end
      if (refill_word_we) begin
        word_we = way_mask_t'(1) << victim_q;
      end
    end
  end

endmodule

//--- hw/icache_top.sv
/* Set-associative instruction cache, physical addresses, read-only
   Wishbone classic master. resp_valid has no back-pressure. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_valid,
  input  icache_pkg::paddr_t  fetch_addr,
  output logic               fetch_ready,
  output logic               resp_valid,
  output icache_pkg::word_t   resp_data,
  output logic               resp_hit,
  input  logic               fence_valid,
  output logic               fence_ready,
  output logic               fence_done,
  output logic               wb_cyc,
  output logic               wb_stb,
  output icache_pkg::paddr_t  wb_adr,
  input  icache_pkg::word_t   wb_dat_i,
  input  logic               wb_ack
);
  import icache_pkg::*;

  way_mask_t                 way_valid;
  tag_t  [`ICACHE_WAYS-1:0]  way_tag;
  word_t [`ICACHE_WAYS-1:0]  way_word;
  index_t                    ram_index;
  offset_t                   ram_offset;
  way_mask_t                 tag_we;
  way_mask_t                 word_we;
  logic                      valid_in;
  tag_t                      tag_in;
  way_idx_t                  victim;
  logic                      victim_step;
  logic                      refill_start;
  paddr_t                    refill_line_addr;
  logic                      refill_word_we;
  offset_t                   refill_offset;
  word_t                     refill_data;
  logic                      refill_done;

  for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
    icache_way_ram u_way (
      .clk       (clk),
      .rst       (rst),
      .index     (ram_index),
      .offset    (ram_offset),
      .tag_we    (tag_we[i]),
      .valid_in  (valid_in),
      .tag_in    (tag_in),
      .word_we   (word_we[i]),
      .word_in   (refill_data),
      .valid_out (way_valid[i]),
      .tag_out   (way_tag[i]),
      .word_out  (way_word[i])
    );
  end

  icache_victim_select u_victim (
    .clk        (clk),
    .rst        (rst),
    .valid_mask (way_valid),
    .step       (victim_step),
    .victim     (victim)
  );

  icache_refill u_refill (
    .clk         (clk),
    .rst         (rst),
    .start       (refill_start),
    .line_addr   (refill_line_addr),
    .wb_dat_i    (wb_dat_i),
    .wb_ack      (wb_ack),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_adr      (wb_adr),
    .word_we     (refill_word_we),
    .word_offset (refill_offset),
    .word_data   (refill_data),
    .done        (refill_done)
  );

  icache_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid      (fetch_valid),
    .fetch_addr       (fetch_addr),
    .fence_valid      (fence_valid),
    .way_valid        (way_valid),
    .way_tag          (way_tag),
    .way_word         (way_word),
    .victim           (victim),
    .refill_word_we   (refill_word_we),
    .refill_offset    (refill_offset),
    .refill_data      (refill_data),
    .refill_done      (refill_done),
    .fetch_ready      (fetch_ready),
    .fence_ready      (fence_ready),
    .fence_done       (fence_done),
    .resp_valid       (resp_valid),
    .resp_data        (resp_data),
    .resp_hit         (resp_hit),
    .ram_index        (ram_index),
    .ram_offset       (ram_offset),
    .tag_we           (tag_we),
    .word_we          (word_we),
    .valid_in         (valid_in),
    .tag_in           (tag_in),
    .refill_start     (refill_start),
    .refill_line_addr (refill_line_addr),
    .victim_step      (victim_step)
  );

endmodule

//--- bench/icache_wb_mem.sv
/* Wishbone classic slave memory for the testbench, read-only.
   Each word is its word address XOR a constant. 0 to 3 wait states per cycle. */
`timescale 1ns/1ps

module icache_wb_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic [31:0] adr,
  output logic [31:0] dat,
  output logic        ack
);

  integer     seed;
  logic [1:0] wait_cnt;

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {2'b00, a[31:2]} ^ 32'h5a3c_96e1;
  endfunction

  initial begin
    seed = 32'h3100484e;
  end

  // Registered ack drops again on the edge where the master sees it
  always @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      dat      <= '0;
      wait_cnt <= '0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        if (wait_cnt == 2'd0) begin
          ack      <= 1'b1;
          dat      <= word_at(adr);
          wait_cnt <= 2'($unsigned($random(seed)) % 4);
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

//--- bench/icache_tb.sv
/* Random fetch and fence traffic over a 3-set address pool.
   Hits are only predicted while a set holds no more lines than ways. */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb;
  import icache_pkg::*;

  localparam int NUM_OPS    = 300;
  localparam int POOL_N     = 13;
  localparam int MAX_CYCLES = 100 + NUM_OPS * 40;

  logic   clk;
  logic   rst;
  logic   fetch_valid;
  paddr_t fetch_addr;
  logic   fetch_ready;
  logic   resp_valid;
  word_t  resp_data;
  logic   resp_hit;
  logic   fence_valid;
  logic   fence_ready;
  logic   fence_done;
  logic   wb_cyc;
  logic   wb_stb;
  paddr_t wb_adr;
  word_t  wb_dat_i;
  logic   wb_ack;

  integer seed;
  int     cycle;
  int     errors;
  int     checks;
  int     ack_cnt;
  paddr_t ack_adr [0:15];
  paddr_t pool [0:POOL_N-1];
  // Up to 8 distinct lines per set since the last fence
  paddr_t seen_line [0:`ICACHE_SETS*8-1];
  int     seen_cnt [0:`ICACHE_SETS-1];

  icache_top u_dut (
    .clk(clk), .rst(rst),
    .fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_ready(fetch_ready),
    .resp_valid(resp_valid), .resp_data(resp_data), .resp_hit(resp_hit),
    .fence_valid(fence_valid), .fence_ready(fence_ready), .fence_done(fence_done),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
  );

  icache_wb_mem u_mem (
    .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb),
    .adr(wb_adr), .dat(wb_dat_i), .ack(wb_ack)
  );

  // ====================
  // Reference model
  function automatic word_t expected_word(input paddr_t a);
    return {2'b00, a[31:2]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic paddr_t make_line(input int tag_sel, input int set);
    return {tag_t'(24'h0c0000 + tag_sel * 24'h000a11), index_t'(set),
            {`ICACHE_INDEX_LSB{1'b0}}};
  endfunction

  task automatic clear_model();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      seen_cnt[s] = 0;
    end
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("FAIL %s: got %h, expected %h (cycle %0d)", name, actual, expected, cycle);
    end
  endtask

  // ====================
  // Clock, cycle count, bus monitor
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    cycle = cycle + 1;
    if (cycle > MAX_CYCLES) begin
      $display("Timeout: no progress within %0d cycles", MAX_CYCLES);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (wb_cyc && wb_stb && wb_ack) begin
      if (ack_cnt < 16) begin
        ack_adr[ack_cnt] = wb_adr;
      end
      ack_cnt = ack_cnt + 1;
    end
  end

  task automatic fence_cache();
    int t0;
    @(negedge clk);
    fence_valid = 1'b1;
    @(posedge clk);
    while (!fence_ready) @(posedge clk);
    t0 = cycle;
    @(negedge clk);
    fence_valid = 1'b0;
    @(posedge clk);
    while (!fence_done) @(posedge clk);
    // Walk over every set, then the done cycle
    check("fence_done latency", cycle - t0, `ICACHE_SETS + 1);
    clear_model();
  endtask

  task automatic fetch_word(input paddr_t addr);
    paddr_t line;
    int     s;
    int     t0;
    int     t1;
    bit     found;
    bit     resident;
    word_t  data;
    logic   hit;
    logic   fetch_rdy;
    logic   fence_rdy;
    line  = addr & ~paddr_t'((1 << `ICACHE_INDEX_LSB) - 1);
    s     = addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    found = 1'b0;
    for (int i = 0; i < seen_cnt[s]; i++) begin
      if (seen_line[s*8+i] == line) found = 1'b1;
    end
    resident = found && (seen_cnt[s] <= `ICACHE_WAYS);
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    @(posedge clk);
    while (!fetch_ready) @(posedge clk);
    t0 = cycle;
    @(negedge clk);
    fetch_valid = 1'b0;
    @(posedge clk);
    while (!resp_valid) @(posedge clk);
    t1        = cycle;
    data      = resp_data;
    hit       = resp_hit;
    fetch_rdy = fetch_ready;
    fence_rdy = fence_ready;
    @(negedge clk);
    check("resp_data", data, expected_word(addr));
    check("fetch_ready", fetch_rdy, 1'b0);
    check("fence_ready", fence_rdy, 1'b0);
    if (!found) check("resp_hit", hit, 1'b0);
    if (resident) check("resp_hit", hit, 1'b1);
    if (hit) begin
      check("hit latency", t1 - t0, 2);
      check("wb ack count", ack_cnt, 0);
    end else begin
      check("wb ack count", ack_cnt, `ICACHE_WORDS);
      if (ack_cnt == `ICACHE_WORDS) begin
        for (int i = 0; i < `ICACHE_WORDS; i++) begin
          check("wb_adr", ack_adr[i], line + 4 * i);
        end
      end
    end
    ack_cnt = 0;
    if (!found) begin
      seen_line[s*8+seen_cnt[s]] = line;
      seen_cnt[s] = seen_cnt[s] + 1;
    end
  endtask

  // ====================
  // Stimulus
  initial begin
    int k;
    int pick;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    fence_valid = 1'b0;
    seed        = 32'h3100484e;
    cycle       = 0;
    errors      = 0;
    checks      = 0;
    ack_cnt     = 0;
    // Set 1 stays within the ways, set 6 fills them, set 11 overflows
    k = 0;
    for (int i = 0; i < 3; i++) begin
      pool[k] = make_line(i, 1);
      k++;
    end
    for (int i = 0; i < 4; i++) begin
      pool[k] = make_line(i + 3, 6);
      k++;
    end
    for (int i = 0; i < 6; i++) begin
      pool[k] = make_line(i + 7, 11);
      k++;
    end
    clear_model();
    repeat (4) @(negedge clk);
    check("resp_valid in reset", resp_valid, 1'b0);
    check("fence_done in reset", fence_done, 1'b0);
    check("wb_cyc in reset", wb_cyc, 1'b0);
    check("wb_stb in reset", wb_stb, 1'b0);
    check("fetch_ready in reset", fetch_ready, 1'b0);
    rst = 1'b0;
    for (int op = 0; op < NUM_OPS; op++) begin
      if (($unsigned($random(seed)) % 25) == 0) begin
        fence_cache();
      end else begin
        pick = $unsigned($random(seed)) % POOL_N;
        fetch_word(pool[pick] | paddr_t'(($unsigned($random(seed)) % 4) << 2));
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hw/icache_pkg.sv
hw/icache_way_ram.sv
hw/icache_victim_select.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_top.sv
bench/icache_wb_mem.sv
bench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/icache_pkg.sv
      - hw/icache_way_ram.sv
      - hw/icache_victim_select.sv
      - hw/icache_refill.sv
      - hw/icache_ctrl.sv
      - hw/icache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/icache_wb_mem.sv
      - bench/icache_tb.sv
